//--- rtl/bufPkg.sv
package bufPkg;

	// ############################
	// sizes
	// ############################

	localparam int wAddrWidth = 5; // word address into the file.
	localparam int wDataWidth = 64; // one fill beat.
	localparam int rDataWidth = 32; // one read entry.

	localparam int halvesPerWord = wDataWidth / rDataWidth;

	// half select sits below the word address.
	localparam int rAddrWidth = wAddrWidth + $clog2(halvesPerWord);

	localparam int numRead = 4; // read lanes.
	localparam int countWidth = 6; // holds 1 to 32.

	localparam int numWords = 2 ** wAddrWidth;
	localparam int numEntries = 2 ** rAddrWidth;

	// ############################
	// types
	// ############################

	// fill beat, seen whole or as low/high halves.
	typedef union packed {
		logic [wDataWidth-1:0] word;
		logic [halvesPerWord-1:0][rDataWidth-1:0] half; // [0] is the low half.
	} fillWordT;

	typedef enum logic [1:0] {
		idle = 2'd0,
		fill = 2'd1,
		done = 2'd2
	} seqStateT;

endpackage

//--- rtl/beatCounter.sv
`timescale 1ns/1ps

module beatCounter (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          clear,
	input  logic                          step,
	input  logic [bufPkg::wAddrWidth-1:0] loadBase,
	input  logic [bufPkg::countWidth-1:0] loadCount,
	output logic [bufPkg::wAddrWidth-1:0] wordAddr,
	output logic                          lastBeat
);
	import bufPkg::*;

	logic [wAddrWidth-1:0] baseReg;
	logic [countWidth-1:0] countReg;
	logic [countWidth-1:0] beatIndex;
	logic [countWidth-1:0] lastIndex;

	// ############################
	// command and index
	// ############################

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			baseReg   <= '0;
			countReg  <= '0;
			beatIndex <= '0;
		end else if (clear) begin
			baseReg   <= loadBase;
			countReg  <= loadCount;
			beatIndex <= '0;
		end else if (step) begin
			beatIndex <= beatIndex + 1'b1;
		end
	end

	// ############################
	// address and last beat
	// ############################

	// 5-bit sum, so the address wraps past word 31.
	assign wordAddr = baseReg + beatIndex[wAddrWidth-1:0];

	assign lastIndex = countReg - 1'b1; // count is never zero here.
	assign lastBeat = (beatIndex == lastIndex);

endmodule

//--- rtl/fillSequencer.sv
`timescale 1ns/1ps

module fillSequencer (
	input  logic                          clk,
	input  logic                          arstN,
	input  logic                          loadStart,
	input  logic [bufPkg::countWidth-1:0] loadCount,
	input  logic                          lastBeat,
	input  logic                          fillValid,
	output logic                          clear,
	output logic                          step,
	output logic                          writeEnable,
	output logic                          busy,
	output logic                          loadDone
);
	import bufPkg::*;

	seqStateT state;
	seqStateT stateNext;
	logic     countZero;
	logic     accept;

	// ############################
	// command qualify
	// ############################

	assign countZero = (loadCount == '0);

	// busy or empty loads are dropped.
	assign accept = loadStart && !busy && !countZero;
	assign clear = accept; // counter takes base and count.

	// ############################
	// beat path
	// ############################

	// no back-pressure, every strobe in fill is a write.
	assign writeEnable = fillValid && (state == fill);
	assign step = writeEnable;

	// ############################
	// state machine
	// ############################

	always_comb begin
		stateNext = state;
		case (state)
			idle: begin
				if (accept) begin
					stateNext = fill;
				end
			end
			fill: begin
				if (writeEnable && lastBeat) begin
					stateNext = done; // last beat written this edge.
				end
			end
			done: begin
				stateNext = idle;
			end
			default: begin
				stateNext = idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
		end else begin
			state <= stateNext;
		end
	end

	assign busy = (state != idle);
	assign loadDone = (state == done); // one cycle, busy still high.

endmodule

//--- rtl/regFile1w4r.sv
`timescale 1ns/1ps

module regFile1w4r (
	input  logic                                              clk,
	input  logic                                              arstN,
	input  logic                                              writeEnable,
	input  logic [bufPkg::wAddrWidth-1:0]                     writeAddr,
	input  bufPkg::fillWordT                                  writeData,
	input  logic [bufPkg::numRead-1:0]                        readEnable,
	input  logic [bufPkg::numRead-1:0][bufPkg::rAddrWidth-1:0] readAddr,
	output logic [bufPkg::numRead-1:0][bufPkg::rDataWidth-1:0] readData
);
	import bufPkg::*;

	logic [rDataWidth-1:0] memEntry [numEntries];
	logic [numWords-1:0]   wordSel;

	// ############################
	// write side
	// ############################

	// one-hot word select, empty when no write.
	always_comb begin
		for (int w = 0; w < numWords; w++) begin
			wordSel[w] = writeEnable && (writeAddr == wAddrWidth'(w));
		end
	end

	// each word lands as consecutive entries, low half first.
	always_ff @(posedge clk) begin
		for (int w = 0; w < numWords; w++) begin
			if (wordSel[w]) begin
				for (int h = 0; h < halvesPerWord; h++) begin
					memEntry[w * halvesPerWord + h] <= writeData.half[h];
				end
			end
		end
	end

	// ############################
	// read lanes
	// ############################

	for (genvar l = 0; l < numRead; l++) begin : gLane
		logic [rAddrWidth-1:0] laneAddr;

		// address held until the lane is enabled again.
		always_ff @(posedge clk or negedge arstN) begin
			if (!arstN) begin
				laneAddr <= '0;
			end else if (readEnable[l]) begin
				laneAddr <= readAddr[l];
			end
		end

		// follows later writes to the held entry.
		assign readData[l] = memEntry[laneAddr];
	end

endmodule

//--- rtl/operandBuffer.sv
`timescale 1ns/1ps

module operandBuffer (
	input  logic                                              clk,
	input  logic                                              arstN,
	input  logic                                              loadStart,
	input  logic [bufPkg::wAddrWidth-1:0]                     loadBase,
	input  logic [bufPkg::countWidth-1:0]                     loadCount,
	input  logic                                              fillValid,
	input  bufPkg::fillWordT                                  fillData,
	input  logic [bufPkg::numRead-1:0]                        readEnable,
	input  logic [bufPkg::numRead-1:0][bufPkg::rAddrWidth-1:0] readAddr,
	output logic                                              busy,
	output logic                                              loadDone,
	output logic [bufPkg::numRead-1:0][bufPkg::rDataWidth-1:0] readData
);
	import bufPkg::*;

	logic                  clear;
	logic                  step;
	logic                  writeEnable;
	logic [wAddrWidth-1:0] wordAddr;
	logic                  lastBeat;

	// ############################
	// fill control
	// ############################

	fillSequencer uSequencer (
		.clk         (clk),
		.arstN       (arstN),
		.loadStart   (loadStart),
		.loadCount   (loadCount),
		.lastBeat    (lastBeat),
		.fillValid   (fillValid),
		.clear       (clear),
		.step        (step),
		.writeEnable (writeEnable),
		.busy        (busy),
		.loadDone    (loadDone)
	);

	beatCounter uCounter (
		.clk       (clk),
		.arstN     (arstN),
		.clear     (clear),
		.step      (step),
		.loadBase  (loadBase),
		.loadCount (loadCount),
		.wordAddr  (wordAddr),
		.lastBeat  (lastBeat)
	);

	// ############################
	// storage
	// ############################

	// fill data goes straight to the write port.
	regFile1w4r uRegFile (
		.clk         (clk),
		.arstN       (arstN),
		.writeEnable (writeEnable),
		.writeAddr   (wordAddr),
		.writeData   (fillData),
		.readEnable  (readEnable),
		.readAddr    (readAddr),
		.readData    (readData)
	);

endmodule

//--- tb/operandBuffer_sva.sv
`timescale 1ns/1ps

module operandBufferSva (
	input logic clk,
	input logic arstN,
	input logic busy,
	input logic loadDone,
	input logic writeEnable
);
	import bufPkg::*;

	seqStateT seqState;

	// sequencer state as seen from the ports.
	assign seqState = !busy ? idle : (loadDone ? done : fill);

	// ##############################
	// load completion
	// ##############################

	doneOneCycle: assert property (@(posedge clk) disable iff (!arstN)
		loadDone |=> !loadDone)
		else $error("loadDone held longer than one cycle");

	doneWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
		loadDone |-> busy)
		else $error("loadDone seen while busy is low");

	busyFallsAfterDone: assert property (@(posedge clk) disable iff (!arstN)
		loadDone |=> !busy)
		else $error("busy still high one cycle after loadDone");

	busyFallsOnlyAfterDone: assert property (@(posedge clk) disable iff (!arstN)
		$fell(busy) |-> $past(loadDone))
		else $error("busy fell without a loadDone the cycle before");

	// ##############################
	// write gating
	// ##############################

	writeOnlyInFill: assert property (@(posedge clk) disable iff (!arstN)
		writeEnable |-> seqState == fill)
		else $error("register file write outside the fill state");

endmodule

bind operandBuffer operandBufferSva uSva (
	.clk         (clk),
	.arstN       (arstN),
	.busy        (busy),
	.loadDone    (loadDone),
	.writeEnable (writeEnable)
);

//--- tb/operandBufferTb.sv
`timescale 1ns/1ps

module operandBufferTb;
	import bufPkg::*;

	logic                               clk;
	logic                               arstN;
	logic                               loadStart;
	logic [wAddrWidth-1:0]              loadBase;
	logic [countWidth-1:0]              loadCount;
	logic                               fillValid;
	fillWordT                           fillData;
	logic [numRead-1:0]                 readEnable;
	logic [numRead-1:0][rAddrWidth-1:0] readAddr;
	logic                               busy;
	logic                               loadDone;
	logic [numRead-1:0][rDataWidth-1:0] readData;

	int              fd;
	int              errors;
	int              checks;
	int              tests;
	int              testErrStart;
	int              testDoneStart;
	int              testLoads;
	bit              testOpen;
	logic [8*24-1:0] testName;
	int              doneSeen;
	logic [31:0]     rngState;

	operandBuffer DUT (
		.clk        (clk),
		.arstN      (arstN),
		.loadStart  (loadStart),
		.loadBase   (loadBase),
		.loadCount  (loadCount),
		.fillValid  (fillValid),
		.fillData   (fillData),
		.readEnable (readEnable),
		.readAddr   (readAddr),
		.busy       (busy),
		.loadDone   (loadDone),
		.readData   (readData)
	);

	// ##############################
	// clock and monitors
	// ##############################

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

	always @(posedge clk) begin
		if (arstN && loadDone) begin
			doneSeen <= doneSeen + 1; // level of the cycle just ended.
		end
	end

	initial begin
		#100000;
		$display("run did not finish within 100 us");
		$display("Simulation FAILED");
		$finish;
	end

	// ##############################
	// helpers
	// ##############################

	function automatic int nextGap();
		rngState = rngState * 32'd1103515245 + 32'd12345;
		return int'(rngState[17:16]); // zero to three idle cycles.
	endfunction

	task automatic checkValue(input string sigName, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error: %s got %h expected %h", sigName, got, exp);
			errors++;
		end
	endtask

	task automatic checkIdle();
		@(negedge clk);
		checkValue("busy", 32'(busy), 0);
		checkValue("loadDone", 32'(loadDone), 0);
	endtask

	task automatic checkLane(input int lane, input logic [31:0] exp);
		@(negedge clk);
		checkValue($sformatf("readData[%0d]", lane), readData[lane], exp);
	endtask

	task automatic waitForDone(input int doneBefore);
		int k;
		@(negedge clk);
		k = 0;
		while (!loadDone && k < 200) begin
			@(negedge clk);
			k++;
		end
		if (!loadDone) begin
			$display("load never signalled loadDone within 200 cycles");
			errors++;
		end else begin
			k = 0;
			while (busy && k < 8) begin
				@(negedge clk);
				k++;
			end
			if (busy) begin
				$display("busy stayed high 8 cycles after loadDone");
				errors++;
			end else begin
				checkValue("busy fall delay", k, 1);
				checkValue("loadDone pulses", doneSeen - doneBefore, 1);
			end
		end
	endtask

	// a second start while busy must be dropped.
	task automatic runLoad(input logic [4:0] base, input logic [5:0] count, input bit intrude,
			input logic [4:0] base2, input logic [5:0] count2);
		logic [63:0] word;
		int          doneBefore;
		int          r;
		doneBefore = doneSeen;
		@(posedge clk);
		loadStart <= 1'b1;
		loadBase <= base;
		loadCount <= count;
		@(posedge clk);
		loadStart <= intrude;
		loadBase <= base2;
		loadCount <= count2;
		@(posedge clk);
		loadStart <= 1'b0;
		for (int i = 0; i < int'(count); i++) begin
			r = $fscanf(fd, "%h", word);
			fillValid <= 1'b0;
			repeat (nextGap()) @(posedge clk);
			fillValid <= 1'b1;
			fillData.word <= word;
			@(posedge clk);
		end
		fillValid <= 1'b0;
		testLoads++;
		waitForDone(doneBefore);
	endtask

	task automatic tryZeroLoad(input logic [4:0] base);
		@(posedge clk);
		loadStart <= 1'b1;
		loadBase <= base;
		loadCount <= '0;
		@(posedge clk);
		loadStart <= 1'b0;
		repeat (3) begin
			@(negedge clk);
			checkValue("busy", 32'(busy), 0);
		end
	endtask

	task automatic strobeIdle(input int num);
		logic [63:0] word;
		int          r;
		for (int i = 0; i < num; i++) begin
			r = $fscanf(fd, "%h", word);
			@(posedge clk);
			fillValid <= 1'b1;
			fillData.word <= word;
		end
		@(posedge clk);
		fillValid <= 1'b0;
		checkIdle();
	endtask

	task automatic enableLanes(input logic [3:0] mask,
			input logic [numRead-1:0][rAddrWidth-1:0] addrs);
		@(posedge clk);
		readEnable <= mask;
		readAddr <= addrs; // disabled lanes get a decoy address.
		@(posedge clk);
		readEnable <= '0;
	endtask

	task automatic readLane(input int lane, input logic [5:0] addr, input logic [31:0] exp);
		logic [numRead-1:0] mask;
		mask = '0;
		mask[lane] = 1'b1;
		@(posedge clk);
		readEnable <= mask;
		readAddr[lane] <= addr;
		@(posedge clk);
		readEnable <= '0;
		checkLane(lane, exp);
	endtask

	task automatic closeTest();
		int testErrs;
		if (testOpen) begin
			checkValue("loadDone pulses in test", doneSeen - testDoneStart, testLoads);
			testErrs = errors - testErrStart;
			if (testErrs == 0) begin
				$display("test %0s: ok", testName);
			end else begin
				$display("test %0s: %0d errors", testName, testErrs);
			end
			tests++;
			testOpen = 1'b0;
		end
	endtask

	// ##############################
	// command interpreter
	// ##############################

	task automatic runFile();
		logic [7:0]                         cmd;
		logic [8*128-1:0]                   lineBuf;
		logic [4:0]                         base;
		logic [4:0]                         base2;
		logic [5:0]                         count;
		logic [5:0]                         count2;
		logic [5:0]                         addr;
		logic [31:0]                        exp;
		logic [3:0]                         mask;
		logic [numRead-1:0][rAddrWidth-1:0] addrs;
		int                                 lane;
		int                                 num;
		int                                 r;
		while ($fscanf(fd, "%s", cmd) == 1) begin
			case (cmd)
				"#": r = $fgets(lineBuf, fd);
				"T": begin
					closeTest();
					r = $fscanf(fd, "%s", testName);
					testOpen = 1'b1;
					testErrStart = errors;
					testDoneStart = doneSeen;
					testLoads = 0;
				end
				"L": begin
					r = $fscanf(fd, "%h %h", base, count);
					runLoad(base, count, 1'b0, '0, '0);
				end
				"X": begin
					r = $fscanf(fd, "%h %h %h %h", base, count, base2, count2);
					runLoad(base, count, 1'b1, base2, count2);
				end
				"Z": begin
					r = $fscanf(fd, "%h", base);
					tryZeroLoad(base);
				end
				"S": begin
					r = $fscanf(fd, "%h", num);
					strobeIdle(num);
				end
				"I": checkIdle();
				"E": begin
					r = $fscanf(fd, "%h", mask);
					for (int l = 0; l < numRead; l++) begin
						r = $fscanf(fd, "%h", addr);
						addrs[l] = addr;
					end
					enableLanes(mask, addrs);
				end
				"H": begin
					r = $fscanf(fd, "%h %h", lane, exp);
					checkLane(lane, exp);
				end
				"R": begin
					r = $fscanf(fd, "%h %h %h", lane, addr, exp);
					readLane(lane, addr, exp);
				end
				default: begin
					$display("unknown stimulus command %s", cmd);
					errors++;
				end
			endcase
		end
	endtask

	initial begin
		rngState = 32'd29090;
		arstN <= 1'b0;
		loadStart <= 1'b0;
		loadBase <= '0;
		loadCount <= '0;
		fillValid <= 1'b0;
		fillData <= '0;
		readEnable <= '0;
		readAddr <= '0;
		repeat (10) @(posedge clk);
		arstN <= 1'b1;
		fd = $fopen("tb/bufferStim.txt", "r");
		if (fd == 0) begin
			$display("stimulus file tb/bufferStim.txt could not be opened");
			errors++;
		end else begin
			runFile();
			$fclose(fd);
		end
		closeTest();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- tb/bufferStim.txt
# hex fields: T name | L base count word.. | X base count base2 count2 word.. | Z base
# S num word.. | I | E mask addr0 addr1 addr2 addr3 | H lane expect | R lane addr expect
T reset
I
L 00 01 5EED00005EED0001
H 0 5EED0001
H 1 5EED0001
H 2 5EED0001
H 3 5EED0001
T fullLoad
L 00 20
C1000000A1000000 C1000001A1000001 C1000002A1000002 C1000003A1000003
C1000004A1000004 C1000005A1000005 C1000006A1000006 C1000007A1000007
C1000008A1000008 C1000009A1000009 C100000AA100000A C100000BA100000B
C100000CA100000C C100000DA100000D C100000EA100000E C100000FA100000F
C1000010A1000010 C1000011A1000011 C1000012A1000012 C1000013A1000013
C1000014A1000014 C1000015A1000015 C1000016A1000016 C1000017A1000017
C1000018A1000018 C1000019A1000019 C100001AA100001A C100001BA100001B
C100001CA100001C C100001DA100001D C100001EA100001E C100001FA100001F
R 0 00 A1000000
R 1 01 C1000000
R 2 3E A100001F
R 3 3F C100001F
R 0 15 C100000A
R 1 26 A1000013
T wrap
L 1E 04 B200001ED200001E B200001FD200001F B2000000D2000000 B2000001D2000001
R 0 3C D200001E
R 1 3D B200001E
R 2 3F B200001F
R 3 00 D2000000
R 0 03 B2000001
R 1 04 A1000002
R 2 3B C100001D
R 3 3A A100001D
T fourLanes
E F 10 21 32 2B
H 0 A1000008
H 1 C1000010
H 2 A1000019
H 3 C1000015
E 5 05 3F 08 3E
H 0 C1000002
H 1 C1000010
H 2 A1000004
H 3 C1000015
L 10 01 7777001066660010
H 1 77770010
H 3 C1000015
T ignored
X 04 02 0C 03 9A0000049B000004 9A0000059B000005
Z 06
S 2 0BADBEEF0BADBEEF 0BADF00D0BADF00D
I
R 0 08 9B000004
R 1 0B 9A000005
R 2 18 A100000C
R 3 19 C100000C
R 0 1C A100000E
R 1 0C A1000006
R 2 0D C1000006
R 3 0A 9B000005

//--- sim.f
rtl/bufPkg.sv
rtl/beatCounter.sv
rtl/fillSequencer.sv
rtl/regFile1w4r.sv
rtl/operandBuffer.sv
tb/operandBuffer_sva.sv
tb/operandBufferTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := operandBufferTb
FILELIST  := sim.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)

SOURCES := $(wildcard rtl/*.sv) $(wildcard tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)
